//--- hw/bitparse_pkg.sv
package bitparse_pkg;

  localparam int word_w = 128;
  localparam int buf_w = 255;
  localparam int len_w = 8;

  typedef enum logic [2:0] {
    mode_xfm    = 3'd0,
    mode_bp     = 3'd1,
    mode_mpp    = 3'd2,
    mode_mppf   = 3'd3,
    mode_bpskip = 3'd4
  } mode_t;

  typedef struct packed {
    logic         csc;
    logic [2:0]   step_size;
    logic [123:0] rest;
  } mpp_view_t;

  typedef struct packed {
    logic [3:0]   use2x2;
    logic [123:0] bpv;
  } bp_view_t;

  // stream bits right after the mode and flatness headers
  typedef union packed {
    mpp_view_t mpp;
    bp_view_t  bp;
  } payload_t;

  localparam logic [2:0] flat_none = 3'd4;
  localparam int intra_bits = 3;

endpackage

//--- hw/funnel_shifter.sv
`timescale 1ns/1ps

module funnel_shifter
(
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  logic [bitparse_pkg::word_w-1:0]   in_data,
  input  logic                              consume,
  input  logic [bitparse_pkg::len_w-1:0]    consume_len,
  output logic [bitparse_pkg::word_w-1:0]   window,
  output logic                              win_valid
);
  import bitparse_pkg::*;

  logic [buf_w-1:0] bit_buf;
  logic [buf_w-1:0] bit_buf_next;
  logic [buf_w-1:0] keep_mask;
  logic [len_w-1:0] fullness;
  logic [len_w-1:0] fullness_next;
  logic [len_w-1:0] shift_len;
  logic [len_w-1:0] remain;
  logic             in_xfer;

  assign in_xfer = in_valid & in_ready;
  assign shift_len = consume ? consume_len : '0;

  // valid bits left after this cycle's consume
  assign remain = fullness - shift_len;

  // only the top remain bits survive, below them the new word goes in
  assign keep_mask = ~({buf_w{1'b1}} >> remain);

  always_comb
  begin
    bit_buf_next = bit_buf << shift_len;
    if (in_xfer)
    begin
      bit_buf_next = (bit_buf_next & keep_mask) |
                     ({in_data, {(buf_w - word_w){1'b0}}} >> remain);
    end
  end

  assign fullness_next = in_xfer ? remain + len_w'(word_w) : remain;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      fullness <= '0;
      in_ready <= 1'b0;
    end
    else
    begin
      fullness <= fullness_next;
      in_ready <= fullness_next < len_w'(word_w);
    end
  end

  always_ff @(posedge clk)
  begin
    bit_buf <= bit_buf_next;
  end

  assign window = bit_buf[buf_w-1 -: word_w];
  assign win_valid = fullness >= len_w'(word_w);

endmodule

//--- hw/mode_header_dec.sv
`timescale 1ns/1ps

module mode_header_dec
(
  input  logic                             clk,
  input  logic                             rstn,
  input  logic [bitparse_pkg::word_w-1:0]  window,
  input  logic                             consume,
  output bitparse_pkg::mode_t              mode,
  output logic [2:0]                       flat_type,
  output logic [bitparse_pkg::len_w-1:0]   hdr_len,
  output bitparse_pkg::payload_t           payload
);
  import bitparse_pkg::*;

  logic              same_flag;
  logic [1:0]        mode_bits;
  logic [len_w-1:0]  mode_len;
  logic [word_w-1:0] after_mode;
  logic              flat_flag;
  mode_t             prev_mode;

  assign same_flag = window[word_w-1];
  assign mode_bits = window[word_w-2 -: 2];

  always_comb
  begin
    if (same_flag)
      mode = prev_mode;
    else
    begin
      case (mode_bits)
        2'd0: mode = mode_xfm;
        2'd1: mode = mode_bp;
        2'd2: mode = mode_mpp;
        // escape code, one more bit picks mppf or bpskip
        default: mode = window[word_w-4] ? mode_bpskip : mode_mppf;
      endcase
    end
  end

  assign mode_len = same_flag ? len_w'(1) : ((&mode_bits) ? len_w'(4) : len_w'(3));

  // flatness flag, then two type bits when set
  assign after_mode = window << mode_len;
  assign flat_flag = after_mode[word_w-1];
  assign flat_type = flat_flag ? {1'b0, after_mode[word_w-2 -: 2]} : flat_none;

  assign hdr_len = mode_len + (flat_flag ? len_w'(3) : len_w'(1));
  assign payload = payload_t'(window << hdr_len);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      prev_mode <= mode_xfm;
    else if (consume)
      prev_mode <= mode;
  end

endmodule

//--- hw/mpp_field_dec.sv
`timescale 1ns/1ps

module mpp_field_dec
#(
  parameter int num_px = 16
)
(
  input  bitparse_pkg::payload_t          payload,
  output logic [2:0]                      step_size,
  output logic [bitparse_pkg::len_w-1:0]  mpp_len
);
  import bitparse_pkg::*;

  logic [2:0] px_bits;

  // csc bit is skipped, step size follows it
  assign step_size = payload.mpp.step_size;

  // each step drops one bit from every sample
  assign px_bits = 3'd7 - step_size;

  // csc + step size + residuals
  assign mpp_len = len_w'(1 + 3 + num_px * px_bits);

endmodule

//--- hw/bp_field_dec.sv
`timescale 1ns/1ps

module bp_field_dec
#(
  parameter int bpv_bits = 6
)
(
  input  bitparse_pkg::payload_t          payload,
  input  logic                            is_fls,
  output logic [3:0]                      use2x2,
  output logic [7:0][5:0]                 bpv,
  output logic [bitparse_pkg::len_w-1:0]  bp_len
);
  import bitparse_pkg::*;

  logic [2:0]        vec_w;
  logic [len_w-1:0]  bit_pos;
  logic [word_w-5:0] vec_src;
  logic [5:0]        vec_raw;
  logic              vec_used;

  // first flag in the stream is sub-block 0
  always_comb
  begin
    for (int k = 0; k < 4; k++)
      use2x2[k] = payload.bp.use2x2[3-k];
  end

  // fixed-length blocks save one bit per vector
  assign vec_w = is_fls ? 3'(bpv_bits - 1) : 3'(bpv_bits);

  // slots 2k and 2k+1 belong to sub-block k
  always_comb
  begin
    bit_pos = '0;
    for (int k = 0; k < 8; k++)
    begin
      vec_used = (k % 2 == 0) || !use2x2[k/2];
      vec_src = payload.bp.bpv << bit_pos;
      vec_raw = vec_src[word_w-5 -: 6] >> (3'd6 - vec_w);
      if (!vec_used)
        bpv[k] = '0;
      else if (is_fls)
        bpv[k] = vec_raw + 6'd32;
      else
        bpv[k] = vec_raw;
      if (vec_used)
        bit_pos = bit_pos + len_w'(vec_w);
    end
  end

  // four flags plus all vectors read
  assign bp_len = bit_pos + len_w'(4);

endmodule

//--- hw/block_length_sel.sv
`timescale 1ns/1ps

module block_length_sel
(
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            win_valid,
  input  bitparse_pkg::mode_t             mode,
  input  logic [2:0]                      flat_type,
  input  logic [bitparse_pkg::len_w-1:0]  hdr_len,
  input  logic                            is_fls,
  input  logic [2:0]                      step_size,
  input  logic [bitparse_pkg::len_w-1:0]  mpp_len,
  input  logic [3:0]                      use2x2,
  input  logic [7:0][5:0]                 bpv,
  input  logic [bitparse_pkg::len_w-1:0]  bp_len,
  output logic                            consume,
  output logic [bitparse_pkg::len_w-1:0]  consume_len,
  output logic                            out_valid,
  input  logic                            out_ready,
  output bitparse_pkg::mode_t             out_mode,
  output logic [2:0]                      out_flat_type,
  output logic [2:0]                      out_step_size,
  output logic [3:0]                      out_use2x2,
  output logic [7:0][5:0]                 out_bpv,
  output logic [bitparse_pkg::len_w-1:0]  out_bits
);
  import bitparse_pkg::*;

  always_comb
  begin
    case (mode)
      // intra bits only when not fixed-length
      mode_xfm: consume_len = is_fls ? hdr_len : hdr_len + len_w'(intra_bits);
      mode_mpp: consume_len = hdr_len + mpp_len;
      mode_bp:  consume_len = hdr_len + bp_len;
      // mppf and bpskip take the header only
      default:  consume_len = hdr_len;
    endcase
  end

  // take a block when the output slot is free or draining
  assign consume = win_valid & (~out_valid | out_ready);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      out_valid <= 1'b0;
    else if (consume)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (consume)
    begin
      out_mode      <= mode;
      out_flat_type <= flat_type;
      out_bits      <= consume_len;
      out_step_size <= (mode == mode_mpp) ? step_size : 3'd0;
      out_use2x2    <= (mode == mode_bp) ? use2x2 : 4'd0;
      out_bpv       <= (mode == mode_bp) ? bpv : '0;
    end
  end

endmodule

//--- hw/bitparse_top.sv
`timescale 1ns/1ps

module bitparse_top
#(
  parameter int num_px   = 16,
  parameter int bpv_bits = 6
)
(
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [bitparse_pkg::word_w-1:0] in_data,
  input  logic                            is_fls,
  output logic                            out_valid,
  input  logic                            out_ready,
  output bitparse_pkg::mode_t             out_mode,
  output logic [2:0]                      out_flat_type,
  output logic [2:0]                      out_step_size,
  output logic [3:0]                      out_use2x2,
  output logic [7:0][5:0]                 out_bpv,
  output logic [bitparse_pkg::len_w-1:0]  out_bits
);
  import bitparse_pkg::*;

  logic [word_w-1:0] window;
  logic              win_valid;
  mode_t             mode;
  logic [2:0]        flat_type;
  logic [len_w-1:0]  hdr_len;
  payload_t          payload;
  logic [2:0]        step_size;
  logic [len_w-1:0]  mpp_len;
  logic [3:0]        use2x2;
  logic [7:0][5:0]   bpv;
  logic [len_w-1:0]  bp_len;
  logic              consume;
  logic [len_w-1:0]  consume_len;

  funnel_shifter shifter_i
  (
    .clk         (clk),
    .rstn        (rstn),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .consume     (consume),
    .consume_len (consume_len),
    .window      (window),
    .win_valid   (win_valid)
  );

  mode_header_dec header_i
  (
    .clk       (clk),
    .rstn      (rstn),
    .window    (window),
    .consume   (consume),
    .mode      (mode),
    .flat_type (flat_type),
    .hdr_len   (hdr_len),
    .payload   (payload)
  );

  // both field decoders see the same payload
  mpp_field_dec #(.num_px(num_px)) mpp_i
  (
    .payload   (payload),
    .step_size (step_size),
    .mpp_len   (mpp_len)
  );

  bp_field_dec #(.bpv_bits(bpv_bits)) bp_i
  (
    .payload (payload),
    .is_fls  (is_fls),
    .use2x2  (use2x2),
    .bpv     (bpv),
    .bp_len  (bp_len)
  );

  block_length_sel sel_i
  (
    .clk           (clk),
    .rstn          (rstn),
    .win_valid     (win_valid),
    .mode          (mode),
    .flat_type     (flat_type),
    .hdr_len       (hdr_len),
    .is_fls        (is_fls),
    .step_size     (step_size),
    .mpp_len       (mpp_len),
    .use2x2        (use2x2),
    .bpv           (bpv),
    .bp_len        (bp_len),
    .consume       (consume),
    .consume_len   (consume_len),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_mode      (out_mode),
    .out_flat_type (out_flat_type),
    .out_step_size (out_step_size),
    .out_use2x2    (out_use2x2),
    .out_bpv       (out_bpv),
    .out_bits      (out_bits)
  );

endmodule

//--- testbench/bitparse_checker.sv
`timescale 1ns/1ps

module bitparse_checker
#(
  parameter int num_px   = 16,
  parameter int bpv_bits = 6
)
(
  input logic        clk,
  input logic        rstn,
  input logic        is_fls,
  input logic        in_ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic [2:0]  out_mode,
  input logic [2:0]  out_flat_type,
  input logic [2:0]  out_step_size,
  input logic [3:0]  out_use2x2,
  input logic [47:0] out_bpv,
  input logic [7:0]  out_bits,
  input int          stream_len
);
  localparam int max_bits = 32768;

  // stream in transmission order, written by the testbench
  logic        stream_bits [0:max_bits-1];
  int          ref_pos;
  logic [2:0]  ref_prev;
  int          pass_blocks;
  int          block_count;
  int          value_errors;
  int          other_errors;
  logic        stalled;
  logic [68:0] held;

  initial
  begin
    block_count = 0;
    value_errors = 0;
    other_errors = 0;
    stalled = 1'b0;
  end

  function automatic logic [31:0] get_bits(input int pos, input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
      val = {val[30:0], (pos + i < max_bits) ? stream_bits[pos + i] : 1'b0};
    return val;
  endfunction

  // bit-level parse of one block, returns the bits it used
  function automatic int parse_block(input int pos, input logic fls, input logic [2:0] prev,
                                     output logic [2:0] mode, output logic [2:0] flat,
                                     output logic [2:0] step, output logic [3:0] use2x2,
                                     output logic [47:0] vecs);
    int         p;
    int         w;
    logic [1:0] mb;
    p = pos;
    step = 3'd0;
    use2x2 = 4'd0;
    vecs = '0;
    if (get_bits(p, 1) == 1)
    begin
      mode = prev;
      p = p + 1;
    end
    else
    begin
      mb = get_bits(p + 1, 2);
      p = p + 3;
      if (mb == 2'd3)
      begin
        mode = get_bits(p, 1) ? 3'd4 : 3'd3;
        p = p + 1;
      end
      else
        mode = 3'(mb);
    end
    if (get_bits(p, 1) == 1)
    begin
      flat = 3'(get_bits(p + 1, 2));
      p = p + 3;
    end
    else
    begin
      flat = 3'd4;
      p = p + 1;
    end
    case (mode)
      3'd0:
        if (!fls)
          p = p + 3;
      3'd2:
      begin
        step = 3'(get_bits(p + 1, 3));
        p = p + 4 + num_px * (7 - step);
      end
      3'd1:
      begin
        for (int k = 0; k < 4; k++)
          use2x2[k] = get_bits(p + k, 1);
        p = p + 4;
        w = fls ? bpv_bits - 1 : bpv_bits;
        // one vector for a 2x2 sub-block, two otherwise
        for (int k = 0; k < 8; k++)
        begin
          if (k % 2 == 0 || !use2x2[k / 2])
          begin
            vecs[k*6 +: 6] = 6'(get_bits(p, w)) + (fls ? 6'd32 : 6'd0);
            p = p + w;
          end
        end
      end
      default: ;
    endcase
    return p - pos;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAILED %s (is_fls %0b, block %0d): expected 0x%0h actual 0x%0h",
               name, is_fls, pass_blocks, exp, act);
    end
  endtask

  task automatic check_block();
    logic [2:0]  exp_mode;
    logic [2:0]  exp_flat;
    logic [2:0]  exp_step;
    logic [3:0]  exp_use2x2;
    logic [47:0] exp_bpv;
    int          len;
    if (stream_len - ref_pos < 128)
    begin
      other_errors++;
      $display("block %0d came out after the last full window of the stream", pass_blocks);
      return;
    end
    len = parse_block(ref_pos, is_fls, ref_prev, exp_mode, exp_flat, exp_step,
                      exp_use2x2, exp_bpv);
    check_value("mode", exp_mode, out_mode);
    check_value("flat_type", exp_flat, out_flat_type);
    check_value("step_size", exp_step, out_step_size);
    check_value("use2x2", exp_use2x2, out_use2x2);
    for (int k = 0; k < 8; k++)
      check_value($sformatf("bpv[%0d]", k), exp_bpv[k*6 +: 6], out_bpv[k*6 +: 6]);
    check_value("bits", len, out_bits);
    ref_pos = ref_pos + len;
    ref_prev = exp_mode;
    pass_blocks++;
    block_count++;
  endtask

  always @(posedge clk)
  begin
    if (!rstn)
    begin
      if (out_valid !== 1'b0 || in_ready !== 1'b0)
      begin
        other_errors++;
        $display("out_valid or in_ready is not low during reset");
      end
      ref_pos = 0;
      ref_prev = 3'd0;
      pass_blocks = 0;
      stalled = 1'b0;
    end
    else
    begin
      if (stalled && (out_valid !== 1'b1 || held !== {out_mode, out_flat_type, out_step_size,
                                                      out_use2x2, out_bpv, out_bits}))
      begin
        other_errors++;
        $display("output block %0d changed while out_ready was low", pass_blocks);
      end
      if (out_valid && out_ready)
        check_block();
      stalled = out_valid && !out_ready;
      held = {out_mode, out_flat_type, out_step_size, out_use2x2, out_bpv, out_bits};
    end
  end

endmodule

//--- testbench/bitparse_tb.sv
`timescale 1ns/1ps

module bitparse_tb;
  localparam int num_px      = 16;
  localparam int bpv_bits    = 6;
  localparam int num_blocks  = 150;
  localparam int word_limit  = 1000;
  localparam int drain_limit = 5000;

  logic         clk;
  logic         rstn;
  logic         in_valid;
  logic         in_ready;
  logic [127:0] in_data;
  logic         is_fls;
  logic         out_valid;
  logic         out_ready;
  logic [2:0]   out_mode;
  logic [2:0]   out_flat_type;
  logic [2:0]   out_step_size;
  logic [3:0]   out_use2x2;
  logic [47:0]  out_bpv;
  logic [7:0]   out_bits;
  logic [31:0]  lfsr_state;
  int           wr_pos;
  int           stream_len;
  int           tb_errors;

  bitparse_top #(.num_px(num_px), .bpv_bits(bpv_bits)) dut_i
  (
    .clk           (clk),
    .rstn          (rstn),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_data       (in_data),
    .is_fls        (is_fls),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_mode      (out_mode),
    .out_flat_type (out_flat_type),
    .out_step_size (out_step_size),
    .out_use2x2    (out_use2x2),
    .out_bpv       (out_bpv),
    .out_bits      (out_bits)
  );

  bitparse_checker #(.num_px(num_px), .bpv_bits(bpv_bits)) check_i
  (
    .clk           (clk),
    .rstn          (rstn),
    .is_fls        (is_fls),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_mode      (out_mode),
    .out_flat_type (out_flat_type),
    .out_step_size (out_step_size),
    .out_use2x2    (out_use2x2),
    .out_bpv       (out_bpv),
    .out_bits      (out_bits),
    .stream_len    (stream_len)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  task automatic put_bits(input logic [31:0] val, input int n);
    for (int i = n - 1; i >= 0; i--)
    begin
      check_i.stream_bits[wr_pos] = val[i];
      wr_pos++;
    end
  endtask

  task automatic gen_block(input logic fls, input logic first, inout logic [2:0] prev);
    logic [2:0] mode;
    logic [2:0] step;
    logic [3:0] flags;
    int         w;
    int         n;
    // the first block after reset always repeats the reset mode
    if (first || take_bits(2) == 0)
    begin
      mode = prev;
      put_bits(1, 1);
    end
    else
    begin
      mode = 3'(take_bits(3) % 5);
      if (mode < 3'd3)
        put_bits(mode, 3);
      else
        put_bits((mode == 3'd4) ? 4'b0111 : 4'b0110, 4);
    end
    if (take_bits(1))
    begin
      put_bits(1, 1);
      put_bits(take_bits(2), 2);
    end
    else
      put_bits(0, 1);
    case (mode)
      3'd0:
        if (!fls)
          put_bits(take_bits(3), 3);
      3'd1:
      begin
        flags = take_bits(4);
        put_bits(flags, 4);
        w = fls ? bpv_bits - 1 : bpv_bits;
        for (int k = 0; k < 4; k++)
        begin
          n = flags[3-k] ? w : 2 * w;
          put_bits(take_bits(n), n);
        end
      end
      3'd2:
      begin
        step = take_bits(3);
        put_bits(take_bits(1), 1);
        put_bits(step, 3);
        for (int i = 0; i < num_px; i++)
          put_bits(take_bits(7 - step), 7 - step);
      end
      default: ;
    endcase
    prev = mode;
  endtask

  task automatic build_stream(input logic fls);
    logic [2:0] prev;
    prev = 3'd0;
    wr_pos = 0;
    for (int b = 0; b < num_blocks; b++)
      gen_block(fls, b == 0, prev);
    // zero fill up to a word, then two zero words of padding
    while (wr_pos % 128 != 0)
      put_bits(0, 1);
    for (int i = 0; i < 8; i++)
      put_bits(0, 32);
    stream_len = wr_pos;
  endtask

  function automatic logic [127:0] stream_word(input int idx);
    logic [127:0] w;
    for (int j = 0; j < 128; j++)
      w[127 - j] = check_i.stream_bits[idx * 128 + j];
    return w;
  endfunction

  task automatic run_pass(input logic fls);
    int   cycles;
    logic taken;
    rstn = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    is_fls = fls;
    build_stream(fls);
    repeat (4)
      @(posedge clk);
    #2;
    rstn = 1'b1;
    for (int i = 0; i < stream_len / 128; i++)
    begin
      in_valid = 1'b1;
      in_data = stream_word(i);
      cycles = 0;
      taken = 1'b0;
      while (!taken && cycles < word_limit)
      begin
        @(posedge clk);
        taken = in_ready;
        #2;
        out_ready = take_bits(2) != 0;
        cycles++;
      end
      if (!taken)
      begin
        tb_errors++;
        $display("timeout: input word %0d was never accepted", i);
        return;
      end
    end
    in_valid = 1'b0;
    cycles = 0;
    while (stream_len - check_i.ref_pos >= 128 && cycles < drain_limit)
    begin
      @(posedge clk);
      #2;
      out_ready = take_bits(2) != 0;
      cycles++;
    end
    if (stream_len - check_i.ref_pos >= 128)
    begin
      tb_errors++;
      $display("timeout: blocks stopped coming out at stream bit %0d", check_i.ref_pos);
      return;
    end
    if (out_valid)
    begin
      tb_errors++;
      $display("an extra block came out after the end of the stream");
    end
    if (check_i.pass_blocks < num_blocks)
    begin
      tb_errors++;
      $display("only %0d blocks came out, %0d were sent", check_i.pass_blocks, num_blocks);
    end
  endtask

  initial
  begin
    rstn = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    is_fls = 1'b0;
    out_ready = 1'b0;
    lfsr_state = 32'hd6d96875;
    tb_errors = 0;
    stream_len = 0;
    #2;
    run_pass(1'b0);
    run_pass(1'b1);
    $display("blocks checked %0d, value errors %0d, other errors %0d", check_i.block_count,
             check_i.value_errors, check_i.other_errors + tb_errors);
    if (check_i.value_errors + check_i.other_errors + tb_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- bitparse.f
hw/bitparse_pkg.sv
hw/funnel_shifter.sv
hw/mode_header_dec.sv
hw/mpp_field_dec.sv
hw/bp_field_dec.sv
hw/block_length_sel.sv
hw/bitparse_top.sv
testbench/bitparse_checker.sv
testbench/bitparse_tb.sv
